/* checker_control.sv */
`timescale 1ns/10ps

module checker_control
    import conflict_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    output logic      in_ready,
    output logic      out_valid,
    input  logic      out_ready,
    input  conflict_t conflicts,
    output logic      accept,
    output logic      check,
    output logic      reject,
    output logic      commit
);

    check_state_t state;
    check_state_t state_next;
    logic         any_conflict;

    // Handshake levels come straight from the state
    assign in_ready  = (state == IDLE);
    assign out_valid = (state == OUTPUT);

    assign any_conflict = conflicts.raw | conflicts.waw | conflicts.war;

    // Strobes for the datapath
    assign accept = in_valid & in_ready;
    assign check  = (state == CHECK);
    assign reject = check & any_conflict;
    assign commit = out_valid & out_ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = CHECK;
                end
            end
            CHECK: begin
                // Single-cycle check, conflicting transactions are dropped here
                if (any_conflict) begin
                    state_next = IDLE;
                end else begin
                    state_next = OUTPUT;
                end
            end
            OUTPUT: begin
                // Wait as long as the downstream side holds off
                if (commit) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* conflict_checker.sv */
`timescale 1ns/10ps

module conflict_checker
    import conflict_pkg::*;
#(
    parameter int CHUNK_SIZE = 16
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  txn_t   in_txn,
    output logic   out_valid,
    input  logic   out_ready,
    output txn_t   out_txn,
    input  logic   batch_completed,
    output count_t raw_conflicts,
    output count_t waw_conflicts,
    output count_t war_conflicts,
    output count_t filter_hits,
    output count_t transactions_processed
);

    logic      accept;
    logic      check;
    logic      reject;
    logic      commit;
    conflict_t conflicts;
    dep_vec_t  batch_reads;
    dep_vec_t  batch_writes;

    checker_control u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .conflicts (conflicts),
        .accept    (accept),
        .check     (check),
        .reject    (reject),
        .commit    (commit)
    );

    // The held transaction is what goes out on the output port
    conflict_detector #(
        .CHUNK_SIZE (CHUNK_SIZE)
    ) u_detector (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept       (accept),
        .in_txn       (in_txn),
        .batch_reads  (batch_reads),
        .batch_writes (batch_writes),
        .held_txn     (out_txn),
        .conflicts    (conflicts)
    );

    dep_set_tracker u_tracker (
        .clk             (clk),
        .rst_n           (rst_n),
        .commit          (commit),
        .held_txn        (out_txn),
        .batch_completed (batch_completed),
        .batch_reads     (batch_reads),
        .batch_writes    (batch_writes)
    );

    stat_counters u_stats (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .check                  (check),
        .reject                 (reject),
        .conflicts              (conflicts),
        .batch_completed        (batch_completed),
        .raw_conflicts          (raw_conflicts),
        .waw_conflicts          (waw_conflicts),
        .war_conflicts          (war_conflicts),
        .filter_hits            (filter_hits),
        .transactions_processed (transactions_processed)
    );

endmodule

/* conflict_detector.sv */
`timescale 1ns/10ps

module conflict_detector
    import conflict_pkg::*;
#(
    parameter int CHUNK_SIZE = 16
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      accept,
    input  txn_t      in_txn,
    input  dep_vec_t  batch_reads,
    input  dep_vec_t  batch_writes,
    output txn_t      held_txn,
    output conflict_t conflicts
);

    localparam int NUM_CHUNKS = DEP_BITS / CHUNK_SIZE;

    txn_t                  txn_q;
    logic [NUM_CHUNKS-1:0] raw_hits;
    logic [NUM_CHUNKS-1:0] waw_hits;
    logic [NUM_CHUNKS-1:0] war_hits;

    // Capture the transaction on the input handshake, hold it until the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_q <= '0;
        end else if (accept) begin
            txn_q <= in_txn;
        end
    end

    assign held_txn = txn_q;

    // Slice-wise overlap against the batch sets
    for (genvar i = 0; i < NUM_CHUNKS; i++) begin : g_chunk
        localparam int LO = i * CHUNK_SIZE;

        // Reads of the new transaction against writes already in the batch
        assign raw_hits[i] = |(txn_q.read_deps[LO +: CHUNK_SIZE]
                               & batch_writes[LO +: CHUNK_SIZE]);

        // Writes against batch writes
        assign waw_hits[i] = |(txn_q.write_deps[LO +: CHUNK_SIZE]
                               & batch_writes[LO +: CHUNK_SIZE]);

        // Writes against batch reads
        assign war_hits[i] = |(txn_q.write_deps[LO +: CHUNK_SIZE]
                               & batch_reads[LO +: CHUNK_SIZE]);
    end

    // Reduce the chunk results into one flag per type
    always_comb begin
        conflicts.raw = |raw_hits;
        conflicts.waw = |waw_hits;
        conflicts.war = |war_hits;
    end

endmodule

/* conflict_input.txt */
// T record: owner_readdeps_writedeps_accept_1 (accept 1 = forwarded, 0 = dropped)
// B record: 2 (batch completed), E record: raw_waw_war_hits_processed_0_3
// Batch one, accepted transactions on chunk edges
5a5a00000000a001_0000000000000001_0000000000010000_1_1
5a5a00000000a002_0000000000008000_0000000080000000_1_1
5a5a00000000a003_0000000100000000_8000000000000000_1_1
// Reads overlap batch reads only
5a5a00000000a004_0000000000008001_0000800000000000_1_1
// RAW on bit 16
5a5a00000000a005_0000000000010000_0001000000000000_0_1
// WAW on bit 63
5a5a00000000a006_0000000000000000_8000000000000000_0_1
// WAR on bit 32
5a5a00000000a007_0000000000000000_0000000100000000_0_1
// RAW on bit 31 and WAR on bit 15
5a5a00000000a008_0000000080000000_0000000000008000_0_1
// All three types
5a5a00000000a009_0000800000000000_0000000000010001_0_1
5a5a00000000a00a_0000000000000002_0000000000000004_1_1
// End of batch one
2
// Same vectors as a005, now free of conflict
5a5a00000000a00b_0000000000010000_0001000000000000_1_1
// RAW on bit 48
5a5a00000000a00c_0001000000000000_0000000000000000_0_1
// WAR on bit 16
5a5a00000000a00d_0000000000000000_0000000000010000_0_1
5a5a00000000a00e_00000000ff000000_0000000000000f00_1_1
5a5a00000000a00f_00000f0000000000_0000000f00000000_1_1
// WAW on bit 11
5a5a00000000a010_0000000000000000_0000000000000800_0_1
// Final counters
00000004_00000003_00000004_00000008_00000006_0_3

/* conflict_monitor.sv */
`timescale 1ns/10ps

module conflict_monitor
    import conflict_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_ready,
    input  logic   out_valid,
    input  logic   out_ready,
    input  txn_t   out_txn,
    input  logic   batch_completed,
    input  count_t raw_conflicts,
    input  count_t waw_conflicts,
    input  count_t war_conflicts,
    input  count_t filter_hits,
    input  count_t transactions_processed,
    input  logic   final_check,
    output int     mismatch_count,
    output int     failure_count,
    output logic   checks_done
);

    localparam int MAX_RECS = 64;

    logic [199:0] recs [0:MAX_RECS-1];
    txn_t         expected_q [$];
    logic         end_found;
    count_t       exp_raw;
    count_t       exp_waw;
    count_t       exp_war;
    count_t       exp_hits;
    count_t       exp_processed;

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("failure at %0t: %s", $time, what);
    endtask

    initial begin
        txn_t t;
        txn_t exp_txn;
        txn_t stall_txn;
        logic stalled;
        logic batch_seen;

        mismatch_count = 0;
        failure_count  = 0;
        checks_done    = 1'b0;
        end_found      = 1'b0;
        stalled        = 1'b0;
        batch_seen     = 1'b0;

        // Accepted transactions in order, and the final counters
        $readmemh("conflict_input.txt", recs);
        for (int i = 0; i < MAX_RECS && !end_found; i++) begin
            if (recs[i][3:0] === 4'h1 && recs[i][7:4] !== 4'h0) begin
                t.owner      = recs[i][199:136];
                t.read_deps  = recs[i][135:72];
                t.write_deps = recs[i][71:8];
                expected_q.push_back(t);
            end else if (recs[i][3:0] === 4'h3) begin
                exp_raw       = recs[i][167:136];
                exp_waw       = recs[i][135:104];
                exp_war       = recs[i][103:72];
                exp_hits      = recs[i][71:40];
                exp_processed = recs[i][39:8];
                end_found     = 1'b1;
            end
        end

        @(posedge rst_n);
        @(negedge clk);
        check_value("in_ready after reset", 64'(in_ready), 64'd1);
        check_value("out_valid after reset", 64'(out_valid), 64'd0);
        check_value("raw_conflicts after reset", 64'(raw_conflicts), 64'd0);
        check_value("waw_conflicts after reset", 64'(waw_conflicts), 64'd0);
        check_value("war_conflicts after reset", 64'(war_conflicts), 64'd0);
        check_value("filter_hits after reset", 64'(filter_hits), 64'd0);
        check_value("transactions_processed after reset", 64'(transactions_processed), 64'd0);

        while (!checks_done) begin
            @(negedge clk);
            if (out_valid) begin
                check_value("in_ready while out_valid is high", 64'(in_ready), 64'd0);
            end
            // Held output must not move while the downstream side stalls
            if (stalled) begin
                if (!out_valid) begin
                    report_failure("out_valid dropped before the output transfer");
                end else begin
                    check_value("out_txn owner under back-pressure", out_txn.owner,
                                stall_txn.owner);
                    check_value("out_txn read_deps under back-pressure", out_txn.read_deps,
                                stall_txn.read_deps);
                    check_value("out_txn write_deps under back-pressure", out_txn.write_deps,
                                stall_txn.write_deps);
                end
            end
            if (batch_seen) begin
                check_value("transactions_processed after batch completion",
                            64'(transactions_processed), 64'd0);
            end
            batch_seen = batch_completed;
            stalled    = out_valid && !out_ready;
            stall_txn  = out_txn;

            // Transfer happens on the coming rising edge
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    report_failure("output transfer while no accepted transaction was expected");
                end else begin
                    exp_txn = expected_q.pop_front();
                    check_value("out_txn owner", out_txn.owner, exp_txn.owner);
                    check_value("out_txn read_deps", out_txn.read_deps, exp_txn.read_deps);
                    check_value("out_txn write_deps", out_txn.write_deps, exp_txn.write_deps);
                end
            end

            if (final_check) begin
                if (!end_found) begin
                    report_failure("input file has no record with the final counter values");
                end else begin
                    check_value("raw_conflicts", 64'(raw_conflicts), 64'(exp_raw));
                    check_value("waw_conflicts", 64'(waw_conflicts), 64'(exp_waw));
                    check_value("war_conflicts", 64'(war_conflicts), 64'(exp_war));
                    check_value("filter_hits", 64'(filter_hits), 64'(exp_hits));
                    check_value("transactions_processed", 64'(transactions_processed),
                                64'(exp_processed));
                end
                if (expected_q.size() != 0) begin
                    report_failure($sformatf("%0d accepted transactions never reached the output",
                                             expected_q.size()));
                end
                checks_done = 1'b1;
            end
        end
    end

endmodule

/* conflict_pkg.sv */
package conflict_pkg;

    // Number of dependency slots tracked per transaction
    localparam int DEP_BITS = 64;

    // One bit per dependency slot
    typedef logic [DEP_BITS-1:0] dep_vec_t;

    // Program owner ID carried with each transaction
    typedef logic [63:0] owner_id_t;

    // Statistics counter width
    typedef logic [31:0] count_t;

    // Transaction payload as it travels through the filter
    typedef struct packed {
        owner_id_t owner;
        dep_vec_t  read_deps;
        dep_vec_t  write_deps;
    } txn_t;

    // Per-type conflict flags for the held transaction
    typedef struct packed {
        logic raw;
        logic waw;
        logic war;
    } conflict_t;

    // Check FSM states
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        CHECK  = 2'b01,
        OUTPUT = 2'b10
    } check_state_t;

endpackage

/* dep_set_tracker.sv */
`timescale 1ns/10ps

module dep_set_tracker
    import conflict_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     commit,
    input  txn_t     held_txn,
    input  logic     batch_completed,
    output dep_vec_t batch_reads,
    output dep_vec_t batch_writes
);

    dep_vec_t reads_q;
    dep_vec_t writes_q;

    // Union of the read and write sets of all transactions committed in this batch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reads_q  <= '0;
            writes_q <= '0;
        end else if (batch_completed) begin
            // Clear beats a commit on the same edge
            reads_q  <= '0;
            writes_q <= '0;
        end else if (commit) begin
            reads_q  <= reads_q | held_txn.read_deps;
            writes_q <= writes_q | held_txn.write_deps;
        end
    end

    assign batch_reads  = reads_q;
    assign batch_writes = writes_q;

endmodule

/* filelist.f */
conflict_pkg.sv
dep_set_tracker.sv
conflict_detector.sv
checker_control.sv
stat_counters.sv
conflict_checker.sv
conflict_monitor.sv
tb_conflict_checker.sv

/* stat_counters.sv */
`timescale 1ns/10ps

module stat_counters
    import conflict_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      check,
    input  logic      reject,
    input  conflict_t conflicts,
    input  logic      batch_completed,
    output count_t    raw_conflicts,
    output count_t    waw_conflicts,
    output count_t    war_conflicts,
    output count_t    filter_hits,
    output count_t    transactions_processed
);

    // Conflict and rejection totals run across batches
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raw_conflicts <= '0;
            waw_conflicts <= '0;
            war_conflicts <= '0;
            filter_hits   <= '0;
        end else if (check) begin
            // One transaction may show more than one type
            if (conflicts.raw) begin
                raw_conflicts <= raw_conflicts + 1'b1;
            end
            if (conflicts.waw) begin
                waw_conflicts <= waw_conflicts + 1'b1;
            end
            if (conflicts.war) begin
                war_conflicts <= war_conflicts + 1'b1;
            end
            if (reject) begin
                filter_hits <= filter_hits + 1'b1;
            end
        end
    end

    // Checked transactions in the current batch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            transactions_processed <= '0;
        end else if (batch_completed) begin
            transactions_processed <= '0;
        end else if (check) begin
            transactions_processed <= transactions_processed + 1'b1;
        end
    end

endmodule

/* tb_conflict_checker.sv */
`timescale 1ns/10ps

module tb_conflict_checker
    import conflict_pkg::*;
();

    // Record layout with the kind in the low nibble
    localparam int REC_BITS  = 200;
    localparam int MAX_RECS  = 64;
    localparam logic [3:0] KIND_TXN   = 4'h1;
    localparam logic [3:0] KIND_BATCH = 4'h2;
    localparam logic [3:0] KIND_END   = 4'h3;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    logic   in_ready;
    txn_t   in_txn;
    logic   out_valid;
    logic   out_ready;
    txn_t   out_txn;
    logic   batch_completed;
    count_t raw_conflicts;
    count_t waw_conflicts;
    count_t war_conflicts;
    count_t filter_hits;
    count_t transactions_processed;

    logic [REC_BITS-1:0] recs [0:MAX_RECS-1];
    int                  num_records;
    logic                records_loaded;
    logic                final_check;
    logic                checks_done;
    int                  mismatch_count;
    int                  failure_count;
    integer              seed;
    logic [31:0]         rnd;

    conflict_checker #(
        .CHUNK_SIZE (16)
    ) DUT (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .in_valid               (in_valid),
        .in_ready               (in_ready),
        .in_txn                 (in_txn),
        .out_valid              (out_valid),
        .out_ready              (out_ready),
        .out_txn                (out_txn),
        .batch_completed        (batch_completed),
        .raw_conflicts          (raw_conflicts),
        .waw_conflicts          (waw_conflicts),
        .war_conflicts          (war_conflicts),
        .filter_hits            (filter_hits),
        .transactions_processed (transactions_processed)
    );

    conflict_monitor u_monitor (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .in_ready               (in_ready),
        .out_valid              (out_valid),
        .out_ready              (out_ready),
        .out_txn                (out_txn),
        .batch_completed        (batch_completed),
        .raw_conflicts          (raw_conflicts),
        .waw_conflicts          (waw_conflicts),
        .war_conflicts          (war_conflicts),
        .filter_hits            (filter_hits),
        .transactions_processed (transactions_processed),
        .final_check            (final_check),
        .mismatch_count         (mismatch_count),
        .failure_count          (failure_count),
        .checks_done            (checks_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Random downstream back-pressure with ready about three cycles in four
    initial begin
        seed      = 32'h569f_1a7f;
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            rnd = $random(seed);
            out_ready <= (rnd[1:0] != 2'b00);
        end
    end

    // Returns on a falling edge with the DUT back in IDLE
    task automatic wait_idle();
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic send_txn(input txn_t t);
        @(posedge clk);
        in_valid <= 1'b1;
        in_txn   <= t;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        // Handshake completes on this edge
        @(posedge clk);
        in_valid <= 1'b0;
        wait_idle();
    endtask

    task automatic pulse_batch();
        @(posedge clk);
        batch_completed <= 1'b1;
        @(posedge clk);
        batch_completed <= 1'b0;
        wait_idle();
    endtask

    initial begin
        txn_t t;

        rst_n           = 1'b0;
        in_valid        = 1'b0;
        in_txn          = '0;
        batch_completed = 1'b0;
        final_check     = 1'b0;
        records_loaded  = 1'b0;

        $readmemh("conflict_input.txt", recs);
        // Records run up to and including the end record
        num_records = MAX_RECS;
        for (int i = MAX_RECS - 1; i >= 0; i--) begin
            if (recs[i][3:0] === KIND_END) begin
                num_records = i + 1;
            end
        end
        records_loaded = 1'b1;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        wait_idle();

        for (int i = 0; i < num_records; i++) begin
            if (recs[i][3:0] === KIND_TXN) begin
                t.owner      = recs[i][199:136];
                t.read_deps  = recs[i][135:72];
                t.write_deps = recs[i][71:8];
                send_txn(t);
            end else if (recs[i][3:0] === KIND_BATCH) begin
                pulse_batch();
            end
        end

        wait_idle();
        final_check = 1'b1;
        wait (checks_done);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the number of records
    initial begin
        wait (records_loaded);
        repeat (num_records * 20 + 100) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles",
                 num_records * 20 + 100);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
